//--- verif/exec_slice_cases.txt
// columns: op addr data resp rdata, all hex; resp 0 is OKAY and 2 is SLVERR
// op 0 write after idle, 1 write back to back, 2 read, 3 drain, 4 end of test, 5 end
2 80 00000000 0 00000000
2 04 00000000 0 00000000
2 7C 00000000 0 00000000
2 84 00000000 2 00000000
4 01 00000000 0 00000000
0 00 123450B7 0 00000000
0 00 FFB00113 0 00000000
0 00 FFC12193 0 00000000
0 00 FFF0B213 0 00000000
0 00 0F017293 0 00000000
0 00 0AB0E313 0 00000000
0 00 FFF14393 0 00000000
0 00 00409413 0 00000000
0 00 01C15493 0 00000000
0 00 40115513 0 00000000
3 00 00000000 0 00000000
2 04 00000000 0 12345000
2 08 00000000 0 FFFFFFFB
2 0C 00000000 0 00000001
2 10 00000000 0 00000001
2 14 00000000 0 000000F0
2 18 00000000 0 123450AB
2 1C 00000000 0 00000004
2 20 00000000 0 23450000
2 24 00000000 0 0000000F
2 28 00000000 0 FFFFFFFD
4 02 00000000 0 00000000
1 00 401105B3 0 00000000
1 00 0015A633 0 00000000
1 00 00B636B3 0 00000000
1 00 02258733 0 00000000
1 00 022717B3 0 00000000
1 00 02F12833 0 00000000
1 00 022838B3 0 00000000
3 00 00000000 0 00000000
2 2C 00000000 0 EDCBAFFB
2 30 00000000 0 00000001
2 34 00000000 0 00000001
2 38 00000000 0 5B059019
2 3C 00000000 0 FFFFFFFE
2 40 00000000 0 FFFFFFFB
2 44 00000000 0 FFFFFFF6
4 03 00000000 0 00000000
0 00 00508013 0 00000000
3 00 00000000 0 00000000
2 00 00000000 0 00000000
4 04 00000000 0 00000000
0 00 0000A283 2 00000000
0 00 00208063 2 00000000
0 00 30009373 2 00000000
0 04 00100293 2 00000000
2 14 00000000 0 000000F0
2 18 00000000 0 123450AB
2 80 00000000 0 00120000
4 05 00000000 0 00000000
0 00 10500073 0 00000000
3 00 00000000 0 00000000
2 80 00000000 0 00130002
0 00 05500313 2 00000000
2 18 00000000 0 123450AB
4 06 00000000 0 00000000
5 00 00000000 0 00000000

//--- exec_slice.f
src/rv32_isa_pkg.sv
src/micro_op_pkg.sv
src/axil_issue_port.sv
src/inst_decode.sv
src/alu_execute.sv
src/reg_writeback.sv
src/exec_slice_top.sv
verif/exec_slice_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the slice and its testbench with Verilator, run it, and pass only
# if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module exec_slice_tb \
	--Mdir obj_dir -o exec_slice_sim -f exec_slice.f \
	&& ./obj_dir/exec_slice_sim | tee /dev/stderr | grep -q -x "STATUS: PASS" \
	&& echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }

//--- verif/exec_slice_tb.sv
// Testbench for the RV32 execution slice.
// Replays bus operations from verif/exec_slice_cases.txt over AXI4-Lite and
// compares responses and read data with the expected columns of each line.
`default_nettype none

module exec_slice_tb;

	localparam int CLOCK_PERIOD = 100;
	localparam int DRIVE_DELAY  = 10;  // inputs change this long after the rising edge
	localparam int MAX_CASES    = 128;
	localparam int WAIT_LIMIT   = 50;  // cycles for one handshake
	localparam int POLL_LIMIT   = 20;  // status reads while draining

	// operation codes of the case file
	localparam logic [31:0] OP_WRITE     = 32'd0; // write after 0..3 random idle cycles
	localparam logic [31:0] OP_WRITE_B2B = 32'd1; // write with no idle cycles
	localparam logic [31:0] OP_READ      = 32'd2;
	localparam logic [31:0] OP_DRAIN     = 32'd3; // poll status until not busy
	localparam logic [31:0] OP_TEST_END  = 32'd4; // address column holds the test number

	logic        clock;
	logic        arst_n;
	logic        awvalid;
	logic        awready;
	logic [7:0]  awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [7:0]  araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        halted;

	logic [31:0] case_mem [0:5*MAX_CASES-1]; // five words per case line
	logic [9:0]  row;
	logic [31:0] op;
	logic [7:0]  addr;
	logic [31:0] data;
	logic [1:0]  exp_resp;
	logic [31:0] exp_data;
	logic [1:0]  got_resp;
	logic [31:0] got_data;
	logic        timed_out;
	logic        list_done;
	integer      seed;
	int          idle;
	int          case_count;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;

	exec_slice_top #(
		.HAS_MUL (1)
	) UUT (
		.clock   (clock),
		.arst_n  (arst_n),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp),
		.halted  (halted)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// bus tasks, all outputs of the DUT are sampled after the drive point
	////////////////////////////////////////////////////////////////////////////
	task automatic next_cycle();
		@(posedge clock);
		#(DRIVE_DELAY);
	endtask

	// returns right after the response shows up, so a following write
	// can be presented in the very next cycle
	task automatic bus_write(input logic [7:0] waddr, input logic [31:0] wword);
		int cycles;
		cycles  = 0;
		awvalid = 1'b1;
		awaddr  = waddr;
		wvalid  = 1'b1;
		wdata   = wword;
		while (!(awready && wready) && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (!(awready && wready)) begin
			$display("timeout: write to 0x%h was never accepted", waddr);
			timed_out = 1'b1;
		end else begin
			next_cycle(); // address and data taken on this edge
			awvalid = 1'b0;
			wvalid  = 1'b0;
			cycles  = 0;
			while (!bvalid && cycles < WAIT_LIMIT) begin
				next_cycle();
				cycles++;
			end
			if (!bvalid) begin
				$display("timeout: no write response for address 0x%h", waddr);
				timed_out = 1'b1;
			end else
				got_resp = bresp; // bready is high, the response completes next edge
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] raddr);
		int cycles;
		cycles  = 0;
		arvalid = 1'b1;
		araddr  = raddr;
		rready  = 1'b1;
		while (!arready && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (!arready) begin
			$display("timeout: read of 0x%h was never accepted", raddr);
			timed_out = 1'b1;
		end else begin
			next_cycle();
			arvalid = 1'b0;
			cycles  = 0;
			while (!rvalid && cycles < WAIT_LIMIT) begin
				next_cycle();
				cycles++;
			end
			if (!rvalid) begin
				$display("timeout: no read data for address 0x%h", raddr);
				timed_out = 1'b1;
			end else begin
				got_resp = rresp;
				got_data = rdata;
				next_cycle();
			end
		end
		arvalid = 1'b0;
		rready  = 1'b0;
	endtask

	// status bit 0 is busy
	task automatic drain_pipeline();
		int polls;
		polls    = 0;
		got_data = 32'h1;
		while (got_data[0] && polls < POLL_LIMIT && !timed_out) begin
			bus_read(8'h80);
			polls++;
		end
		if (got_data[0] && !timed_out) begin
			$display("timeout: slice still busy after %0d status reads", polls);
			timed_out = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// case replay
	////////////////////////////////////////////////////////////////////////////
	initial begin
		arst_n       = 1'b0;
		awvalid      = 1'b0;
		awaddr       = 8'h00;
		wvalid       = 1'b0;
		wdata        = 32'h0;
		bready       = 1'b1; // write responses are always accepted
		arvalid      = 1'b0;
		araddr       = 8'h00;
		rready       = 1'b0;
		got_resp     = 2'b00;
		got_data     = 32'h0;
		timed_out    = 1'b0;
		list_done    = 1'b0;
		seed         = 35;
		row          = 10'd0;
		case_count   = 0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		$readmemh("verif/exec_slice_cases.txt", case_mem);

		repeat (3) @(posedge clock);
		#(DRIVE_DELAY);
		arst_n = 1'b1;

		while (!list_done && !timed_out && case_count < MAX_CASES) begin
			op       = case_mem[row];
			addr     = case_mem[row + 10'd1][7:0];
			data     = case_mem[row + 10'd2];
			exp_resp = case_mem[row + 10'd3][1:0];
			exp_data = case_mem[row + 10'd4];
			case (op)
				OP_WRITE, OP_WRITE_B2B: begin
					if (op == OP_WRITE) begin
						idle = $random(seed) & 3;
						repeat (idle) next_cycle();
					end
					bus_write(addr, data);
					if (!timed_out && got_resp !== exp_resp) begin
						$display("mismatch: bresp line %0d expected %h got %h",
							case_count, exp_resp, got_resp);
						test_errors++;
					end
				end
				OP_READ: begin
					bus_read(addr);
					if (!timed_out && got_resp !== exp_resp) begin
						$display("mismatch: rresp line %0d expected %h got %h",
							case_count, exp_resp, got_resp);
						test_errors++;
					end
					if (!timed_out && got_data !== exp_data) begin
						$display("mismatch: rdata at 0x%h expected %h got %h",
							addr, exp_data, got_data);
						test_errors++;
					end
					// status bit 1 is the halted output as well
					if (!timed_out && addr == 8'h80 && halted !== exp_data[1]) begin
						$display("mismatch: halted expected %h got %h",
							exp_data[1], halted);
						test_errors++;
					end
				end
				OP_DRAIN: drain_pipeline();
				OP_TEST_END: begin
					tests_run++;
					if (test_errors == 0)
						$display("test %0d passed", addr);
					else begin
						$display("test %0d failed with %0d errors", addr, test_errors);
						tests_failed++;
					end
					errors      = errors + test_errors;
					test_errors = 0;
				end
				default: list_done = 1'b1; // end of the list
			endcase
			row = row + 10'd5;
			case_count++;
		end

		if (!list_done && !timed_out) begin
			$display("the case list has no end line");
			errors++;
		end
		if (tests_run == 0)
			$display("no test ran, the case file was not read");
		errors = errors + test_errors;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_run > 0 && !timed_out && list_done)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/exec_slice_top.sv
// Top of the RV32 execution slice. Connects the AXI4-Lite port to the
// decode, execute and writeback stages; HAS_MUL enables the multiply group.
`default_nettype none

module exec_slice_top
	import rv32_isa_pkg::*;
	import micro_op_pkg::*;
#(
	parameter int HAS_MUL = 1
) (
	input  wire         clock,
	input  wire         arst_n,
	input  wire         awvalid,
	output logic        awready,
	input  wire  [7:0]  awaddr,
	input  wire         wvalid,
	output logic        wready,
	input  wire  [31:0] wdata,
	output logic        bvalid,
	input  wire         bready,
	output logic [1:0]  bresp,
	input  wire         arvalid,
	output logic        arready,
	input  wire  [7:0]  araddr,
	output logic        rvalid,
	input  wire         rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        halted
);

	logic        issue_valid;
	rv32_inst_t  issue_inst;
	logic        inst_illegal;
	logic [15:0] retire_count;
	reg_idx_t    rf_raddr;
	xlen_t       rf_rdata;
	reg_idx_t    rs1_idx;
	reg_idx_t    rs2_idx;
	xlen_t       rs1_data;
	xlen_t       rs2_data;

	// decode to execute
	logic        ex_valid;
	alu_func_t   ex_alu_func;
	opa_select_t ex_opa_select;
	opb_select_t ex_opb_select;
	xlen_t       ex_rs1_value;
	xlen_t       ex_rs2_value;
	xlen_t       ex_imm;
	reg_idx_t    ex_rd;
	logic        ex_halt;

	// execute to writeback
	logic        wb_valid;
	reg_idx_t    wb_rd;
	xlen_t       wb_result;
	logic        wb_halt;

	// last writeback, forwarded one more cycle
	logic        fwd_valid;
	reg_idx_t    fwd_rd;
	xlen_t       fwd_result;

	axil_issue_port u_port (
		.clock        (clock),
		.arst_n       (arst_n),
		.awvalid      (awvalid),
		.awready      (awready),
		.awaddr       (awaddr),
		.wvalid       (wvalid),
		.wready       (wready),
		.wdata        (wdata),
		.bvalid       (bvalid),
		.bready       (bready),
		.bresp        (bresp),
		.arvalid      (arvalid),
		.arready      (arready),
		.araddr       (araddr),
		.rvalid       (rvalid),
		.rready       (rready),
		.rdata        (rdata),
		.rresp        (rresp),
		.issue_valid  (issue_valid),
		.issue_inst   (issue_inst),
		.inst_illegal (inst_illegal),
		.halted       (halted),
		.busy         (ex_valid | wb_valid), // any stage occupied
		.retire_count (retire_count),
		.rf_raddr     (rf_raddr),
		.rf_rdata     (rf_rdata)
	);

	inst_decode #(
		.HAS_MUL (HAS_MUL)
	) u_decode (
		.clock         (clock),
		.arst_n        (arst_n),
		.issue_valid   (issue_valid),
		.issue_inst    (issue_inst),
		.inst_illegal  (inst_illegal),
		.rf_rs1_idx    (rs1_idx),
		.rf_rs2_idx    (rs2_idx),
		.rf_rs1_data   (rs1_data),
		.rf_rs2_data   (rs2_data),
		.ex_fwd_valid  (wb_valid),
		.ex_fwd_rd     (wb_rd),
		.ex_fwd_result (wb_result),
		.wb_fwd_valid  (fwd_valid),
		.wb_fwd_rd     (fwd_rd),
		.wb_fwd_result (fwd_result),
		.ex_valid      (ex_valid),
		.ex_alu_func   (ex_alu_func),
		.ex_opa_select (ex_opa_select),
		.ex_opb_select (ex_opb_select),
		.ex_rs1_value  (ex_rs1_value),
		.ex_rs2_value  (ex_rs2_value),
		.ex_imm        (ex_imm),
		.ex_rd         (ex_rd),
		.ex_halt       (ex_halt)
	);

	alu_execute u_execute (
		.clock         (clock),
		.arst_n        (arst_n),
		.ex_valid      (ex_valid),
		.ex_alu_func   (ex_alu_func),
		.ex_opa_select (ex_opa_select),
		.ex_opb_select (ex_opb_select),
		.ex_rs1_value  (ex_rs1_value),
		.ex_rs2_value  (ex_rs2_value),
		.ex_imm        (ex_imm),
		.ex_rd         (ex_rd),
		.ex_halt       (ex_halt),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_result     (wb_result),
		.wb_halt       (wb_halt)
	);

	reg_writeback u_writeback (
		.clock        (clock),
		.arst_n       (arst_n),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_result    (wb_result),
		.wb_halt      (wb_halt),
		.rs1_idx      (rs1_idx),
		.rs2_idx      (rs2_idx),
		.rf_raddr     (rf_raddr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.rf_rdata     (rf_rdata),
		.halted       (halted),
		.retire_count (retire_count),
		.fwd_valid    (fwd_valid),
		.fwd_rd       (fwd_rd),
		.fwd_result   (fwd_result)
	);

endmodule

`default_nettype wire

//--- src/reg_writeback.sv
// Result stage. Holds x1..x31, writes results back, counts retired
// instructions and keeps the sticky halted bit set by WFI.
// The last writeback is kept one more cycle as a forwarding source.
`default_nettype none

module reg_writeback
	import micro_op_pkg::*;
(
	input  wire          clock,
	input  wire          arst_n,
	input  wire          wb_valid,
	input  reg_idx_t     wb_rd,
	input  xlen_t        wb_result,
	input  wire          wb_halt,
	input  reg_idx_t     rs1_idx,
	input  reg_idx_t     rs2_idx,
	input  reg_idx_t     rf_raddr,  // host read port
	output xlen_t        rs1_data,
	output xlen_t        rs2_data,
	output xlen_t        rf_rdata,
	output logic         halted,
	output logic [15:0]  retire_count,
	output logic         fwd_valid,
	output reg_idx_t     fwd_rd,
	output xlen_t        fwd_result
);

	xlen_t regs [1:31]; // x0 is not stored

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];
	assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
			halted       <= 1'b0;
			retire_count <= '0;
			fwd_valid    <= 1'b0;
		end else begin
			if (wb_valid && wb_rd != '0)
				regs[wb_rd] <= wb_result;
			if (wb_valid)
				retire_count <= retire_count + 16'd1; // wfi counts too
			if (wb_valid && wb_halt)
				halted <= 1'b1;
			fwd_valid <= wb_valid;
		end
	end

	always_ff @(posedge clock) begin
		fwd_rd     <= wb_rd;
		fwd_result <= wb_result;
	end

endmodule

`default_nettype wire

//--- src/alu_execute.sv
// Execute stage. Picks the ALU operands, computes the result including
// the multiply group, and registers it toward writeback.
// The registered outputs are also the execute forwarding source for decode.
`default_nettype none

module alu_execute
	import micro_op_pkg::*;
(
	input  wire          clock,
	input  wire          arst_n,
	input  wire          ex_valid,
	input  alu_func_t    ex_alu_func,
	input  opa_select_t  ex_opa_select,
	input  opb_select_t  ex_opb_select,
	input  xlen_t        ex_rs1_value,
	input  xlen_t        ex_rs2_value,
	input  xlen_t        ex_imm,
	input  reg_idx_t     ex_rd,
	input  wire          ex_halt,
	output logic         wb_valid,
	output reg_idx_t     wb_rd,
	output xlen_t        wb_result,
	output logic         wb_halt
);

	xlen_t              opa;
	xlen_t              opb;
	xlen_t              alu_result;
	logic               a_signed;
	logic               b_signed;
	logic signed [32:0] mul_a;
	logic signed [32:0] mul_b;
	logic signed [65:0] product;

	assign opa = (ex_opa_select == OPA_IS_ZERO) ? '0 : ex_rs1_value;
	assign opb = (ex_opb_select == OPB_IS_IMM) ? ex_imm : ex_rs2_value;

	// one 33x33 signed multiplier serves all four ops
	assign a_signed = (ex_alu_func == ALU_MULH) || (ex_alu_func == ALU_MULHSU);
	assign b_signed = (ex_alu_func == ALU_MULH);
	assign mul_a    = {a_signed & opa[31], opa};
	assign mul_b    = {b_signed & opb[31], opb};
	assign product  = {{33{mul_a[32]}}, mul_a} * {{33{mul_b[32]}}, mul_b};

	always_comb begin
		case (ex_alu_func)
			ALU_ADD:    alu_result = opa + opb;
			ALU_SUB:    alu_result = opa - opb;
			ALU_SLT:    alu_result = {31'b0, $signed(opa) < $signed(opb)};
			ALU_SLTU:   alu_result = {31'b0, opa < opb};
			ALU_AND:    alu_result = opa & opb;
			ALU_OR:     alu_result = opa | opb;
			ALU_XOR:    alu_result = opa ^ opb;
			ALU_SLL:    alu_result = opa << opb[4:0];
			ALU_SRL:    alu_result = opa >> opb[4:0];
			ALU_SRA:    alu_result = $signed(opa) >>> opb[4:0];
			ALU_MUL:    alu_result = product[31:0];
			ALU_MULH,
			ALU_MULHSU,
			ALU_MULHU:  alu_result = product[63:32];
			default:    alu_result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_valid;
	end

	always_ff @(posedge clock) begin
		wb_rd     <= ex_rd;
		wb_result <= alu_result;
		wb_halt   <= ex_halt;
	end

endmodule

`default_nettype wire

//--- src/inst_decode.sv
// Decode stage. Turns an issued word into ALU controls and an immediate,
// flags illegal words to the port in the same cycle, and reads operands
// out of the decode register with forwarding from execute and writeback.
`default_nettype none

module inst_decode
	import rv32_isa_pkg::*;
	import micro_op_pkg::*;
#(
	parameter int HAS_MUL = 1
) (
	input  wire          clock,
	input  wire          arst_n,
	input  wire          issue_valid,
	input  rv32_inst_t   issue_inst,
	output logic         inst_illegal,
	// register file read
	output reg_idx_t     rf_rs1_idx,
	output reg_idx_t     rf_rs2_idx,
	input  xlen_t        rf_rs1_data,
	input  xlen_t        rf_rs2_data,
	// in-flight results
	input  wire          ex_fwd_valid,
	input  reg_idx_t     ex_fwd_rd,
	input  xlen_t        ex_fwd_result,
	input  wire          wb_fwd_valid,
	input  reg_idx_t     wb_fwd_rd,
	input  xlen_t        wb_fwd_result,
	// to execute
	output logic         ex_valid,
	output alu_func_t    ex_alu_func,
	output opa_select_t  ex_opa_select,
	output opb_select_t  ex_opb_select,
	output xlen_t        ex_rs1_value,
	output xlen_t        ex_rs2_value,
	output xlen_t        ex_imm,
	output reg_idx_t     ex_rd,
	output logic         ex_halt
);

	alu_func_t   dec_func;
	opa_select_t dec_opa;
	opb_select_t dec_opb;
	logic        dec_halt;
	xlen_t       dec_imm;
	reg_idx_t    rs1_idx_q;
	reg_idx_t    rs2_idx_q;

	// funct3 to ALU function, shared by the immediate and register groups
	function automatic alu_func_t base_func(input logic [2:0] funct3);
		case (funct3)
			F3_ADD:  base_func = ALU_ADD;
			F3_SLL:  base_func = ALU_SLL;
			F3_SLT:  base_func = ALU_SLT;
			F3_SLTU: base_func = ALU_SLTU;
			F3_XOR:  base_func = ALU_XOR;
			F3_SR:   base_func = ALU_SRL; // sra picked by funct7
			F3_OR:   base_func = ALU_OR;
			F3_AND:  base_func = ALU_AND;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		dec_func     = ALU_ADD;
		dec_opa      = OPA_IS_RS1;
		dec_opb      = OPB_IS_RS2;
		dec_halt     = 1'b0;
		inst_illegal = 1'b0;
		case (issue_inst.r.opcode)
			OP_LUI: begin
				dec_opa = OPA_IS_ZERO;
				dec_opb = OPB_IS_IMM;
			end
			OP_IMM: begin
				dec_opb  = OPB_IS_IMM;
				dec_func = base_func(issue_inst.i.funct3);
				// shift immediates keep funct7 in the top of imm12
				if (issue_inst.i.funct3 == F3_SLL)
					inst_illegal = (issue_inst.r.funct7 != F7_BASE);
				else if (issue_inst.i.funct3 == F3_SR) begin
					if (issue_inst.r.funct7 == F7_ALT)
						dec_func = ALU_SRA;
					else if (issue_inst.r.funct7 != F7_BASE)
						inst_illegal = 1'b1;
				end
			end
			OP_REG: begin
				case (issue_inst.r.funct7)
					F7_BASE: dec_func = base_func(issue_inst.r.funct3);
					F7_ALT: begin
						if (issue_inst.r.funct3 == F3_ADD)
							dec_func = ALU_SUB;
						else if (issue_inst.r.funct3 == F3_SR)
							dec_func = ALU_SRA;
						else
							inst_illegal = 1'b1;
					end
					F7_MULDIV: begin
						// div and rem are not implemented
						case (issue_inst.r.funct3)
							F3_ADD:  dec_func = ALU_MUL;
							F3_SLL:  dec_func = ALU_MULH;
							F3_SLT:  dec_func = ALU_MULHSU;
							F3_SLTU: dec_func = ALU_MULHU;
							default: inst_illegal = 1'b1;
						endcase
						if (HAS_MUL == 0)
							inst_illegal = 1'b1;
					end
					default: inst_illegal = 1'b1;
				endcase
			end
			OP_SYSTEM: begin
				if (issue_inst == INST_WFI) begin
					dec_halt = 1'b1;
					dec_opa  = OPA_IS_ZERO;
				end else
					inst_illegal = 1'b1; // csr and the rest
			end
			default: inst_illegal = 1'b1;
		endcase
	end

	// U immediate for lui, sign extended I immediate otherwise
	assign dec_imm = (issue_inst.r.opcode == OP_LUI) ?
		{issue_inst.i.imm12, issue_inst.i.rs1, issue_inst.i.funct3, 12'h000} :
		{{20{issue_inst.i.imm12[11]}}, issue_inst.i.imm12};

	////////////////////////////////////////////////////////////////////////////
	// decode register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= issue_valid & ~inst_illegal;
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			ex_alu_func   <= dec_func;
			ex_opa_select <= dec_opa;
			ex_opb_select <= dec_opb;
			ex_imm        <= dec_imm;
			ex_rd         <= issue_inst.r.rd;
			ex_halt       <= dec_halt;
			rs1_idx_q     <= issue_inst.r.rs1;
			rs2_idx_q     <= issue_inst.r.rs2;
		end
	end

	// operand read, the execute result is younger than the writeback one
	assign rf_rs1_idx = rs1_idx_q;
	assign rf_rs2_idx = rs2_idx_q;

	always_comb begin
		ex_rs1_value = rf_rs1_data;
		ex_rs2_value = rf_rs2_data;
		if (wb_fwd_valid && wb_fwd_rd != '0 && wb_fwd_rd == rs1_idx_q)
			ex_rs1_value = wb_fwd_result;
		if (ex_fwd_valid && ex_fwd_rd != '0 && ex_fwd_rd == rs1_idx_q)
			ex_rs1_value = ex_fwd_result;
		if (wb_fwd_valid && wb_fwd_rd != '0 && wb_fwd_rd == rs2_idx_q)
			ex_rs2_value = wb_fwd_result;
		if (ex_fwd_valid && ex_fwd_rd != '0 && ex_fwd_rd == rs2_idx_q)
			ex_rs2_value = ex_fwd_result;
	end

endmodule

`default_nettype wire

//--- src/axil_issue_port.sv
// AXI4-Lite slave of the execution slice.
// A write to 0x00 issues one instruction; reads return x0..x31 or the status word.
// Only bready and rready can stall this port.
`default_nettype none

module axil_issue_port
	import rv32_isa_pkg::*;
(
	input  wire               clock,
	input  wire               arst_n,
	// write channels
	input  wire               awvalid,
	output logic              awready,
	input  wire  [7:0]        awaddr,
	input  wire               wvalid,
	output logic              wready,
	input  wire  [31:0]       wdata,
	output logic              bvalid,
	input  wire               bready,
	output logic [1:0]        bresp,
	// read channels
	input  wire               arvalid,
	output logic              arready,
	input  wire  [7:0]        araddr,
	output logic              rvalid,
	input  wire               rready,
	output logic [31:0]       rdata,
	output logic [1:0]        rresp,
	// slice side
	output logic              issue_valid,
	output rv32_inst_t        issue_inst,
	input  wire               inst_illegal,
	input  wire               halted,
	input  wire               busy,
	input  wire  [15:0]       retire_count,
	output logic [4:0]        rf_raddr,
	input  wire  [31:0]       rf_rdata
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [7:0] ISSUE_ADDR  = 8'h00;
	localparam logic [7:0] STATUS_ADDR = 8'h80;

	logic        wr_take;
	logic        rd_take;
	logic        reg_hit;
	logic [31:0] status_word;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////
	// a response accepted in this cycle frees the channel for the next issue
	assign awready = ~bvalid | bready;
	assign wready  = ~bvalid | bready; // both readies move together
	assign wr_take = awvalid & wvalid & awready;

	assign issue_valid = wr_take & (awaddr == ISSUE_ADDR) & ~halted;
	assign issue_inst  = wdata;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			bvalid <= 1'b0;
		else if (wr_take)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	// decode answers legality in the same cycle
	always_ff @(posedge clock) begin
		if (wr_take)
			bresp <= (issue_valid && !inst_illegal) ? RESP_OKAY : RESP_SLVERR;
	end

	////////////////////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////////////////////
	assign arready     = ~rvalid;
	assign rd_take     = arvalid & ~rvalid;
	assign rf_raddr    = araddr[6:2];
	assign reg_hit     = ~araddr[7] & (araddr[1:0] == 2'b00); // 0x00..0x7c, aligned
	assign status_word = {retire_count, 14'h0000, halted, busy};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			rvalid <= 1'b0;
		else if (rd_take)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (rd_take) begin
			if (reg_hit) begin
				rdata <= rf_rdata;
				rresp <= RESP_OKAY;
			end else if (araddr == STATUS_ADDR) begin
				rdata <= status_word;
				rresp <= RESP_OKAY;
			end else begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/micro_op_pkg.sv
// Datapath control types passed from decode to execute and writeback.
// Decode fills them in, the later stages only consume them.
`default_nettype none

package micro_op_pkg;

	typedef logic [4:0]  reg_idx_t; // architectural register number
	typedef logic [31:0] xlen_t;

	////////////////////////////////////////////////////////////////////////////
	// ALU function and operand selects
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,    // low product word
		ALU_MULH,   // signed x signed, high word
		ALU_MULHSU, // signed x unsigned, high word
		ALU_MULHU   // unsigned x unsigned, high word
	} alu_func_t;

	typedef enum logic {
		OPA_IS_RS1,
		OPA_IS_ZERO // lui
	} opa_select_t;

	typedef enum logic {
		OPB_IS_RS2,
		OPB_IS_IMM
	} opb_select_t;

endpackage

`default_nettype wire

//--- src/rv32_isa_pkg.sv
// RV32 instruction encoding shared by the issue port, decode and the testbench.
// Holds the opcode and funct constants and the two views of an instruction word.
`default_nettype none

package rv32_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction word, read as R-type or as I-type
	////////////////////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12; // also the top of the U immediate
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} rv32_inst_t;

	// major opcodes handled by the slice
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, mul
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // srl and sra
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	localparam logic [31:0] INST_WFI = 32'h10500073;

endpackage

`default_nettype wire
